//--- Bender.yml
package:
  name: lander_io

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/lander_pkg.sv
      - hw/lander_controls.sv
      - hw/lander_difficulty.sv
      - hw/lander_video_out.sv
      - hw/lander_i2s_tx.sv
      - hw/lander_io_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/lander_checker.sv
      - dv/lander_tb.sv

//--- dv/lander_checker.sv
// concurrent checks on the lander top-level outputs
// attached to every lander_io_top by the bind at the end of this file

`include "lander_settings.svh"

module lander_checker import lander_pkg::*; (
  input logic    clk_50,
  input logic    i_rst_n,
  input thrust_t o_thrust,
  input rgb24_t  o_rgb,
  input logic    o_de,
  input logic    o_hs,
  input logic    o_vs,
  input logic    o_sclk
);
  timeunit 1ns;
  timeprecision 100ps;

  // throttle saturates at its ceiling
  thrust_max: assert property (@(posedge clk_50) disable iff (!i_rst_n)
    o_thrust <= thrust_t'(`LL_THRUST_MAX))
    else $error("o_thrust above its ceiling");

  // black outside the active area
  rgb_blank: assert property (@(posedge clk_50) disable iff (!i_rst_n)
    !o_de |-> (o_rgb == '0))
    else $error("o_rgb nonzero while o_de is low");

  // sync starts are single-cycle pulses
  hs_pulse: assert property (@(posedge clk_50) disable iff (!i_rst_n) o_hs |=> !o_hs)
    else $error("o_hs high for two cycles");
  vs_pulse: assert property (@(posedge clk_50) disable iff (!i_rst_n) o_vs |=> !o_vs)
    else $error("o_vs high for two cycles");

  // bit clock never toggles on back-to-back cycles
  sclk_spacing: assert property (@(posedge clk_50) disable iff (!i_rst_n)
    !$stable(o_sclk) |=> $stable(o_sclk))
    else $error("o_sclk toggled on consecutive cycles");

endmodule

bind lander_io_top lander_checker u_checker (
  .clk_50   (clk_50),
  .i_rst_n  (i_rst_n),
  .o_thrust (o_thrust),
  .o_rgb    (o_rgb),
  .o_de     (o_de),
  .o_hs     (o_hs),
  .o_vs     (o_vs),
  .o_sclk   (o_sclk)
);

//--- dv/lander_tb.sv
// testbench for the lander glue logic top
// seeded random controller, lamp, video and audio stimulus, checked every
// cycle against models kept here; run through list.f with lander_tb on top

`include "lander_settings.svh"

module lander_tb import lander_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // short ticks so every path is exercised in a few thousand cycles
  localparam int THRUST_TICK_TB = 20;
  localparam int DIFF_SHOW_TB   = 50;
  localparam int SCLK_STEP_TB   = 1;
  localparam int SCLK_MOD_TB    = 4;
  localparam int CLK_PERIOD     = 10;
  localparam int RESET_CYC      = 8;
  // 128 sclk half periods per stereo frame
  localparam int FRAME_CYC      = 128 * SCLK_MOD_TB / SCLK_STEP_TB;
  localparam int NPHASE         = 16;
  // enough steps to sweep the whole throttle range
  localparam int RAMP_LEN       = 260 * (THRUST_TICK_TB + 1);

  logic clk_50 = 1'b0;
  logic i_rst_n;
  cont_key_t i_cont1_key, i_cont2_key;
  logic o_rot_left_n, o_rot_right_n, o_abort_n, o_start_n, o_coin_n, o_game_sel_n;
  thrust_t o_thrust;
  logic i_lamp3, i_lamp4, i_lamp5;
  diff_t o_difficulty;
  logic o_diff_show;
  color3_t i_r, i_g, i_b;
  logic i_hsync_n, i_vsync_n, i_hblank, i_vblank;
  rgb24_t o_rgb;
  logic o_de, o_hs, o_vs;
  audio_t i_audio;
  logic o_sclk, o_lrck, o_dac;

  integer seed = 34;
  int phase_len [NPHASE];
  logic [1:0] phase_ab [NPHASE];
  longint total_cycles = 0;

  // inputs as last applied, and the audio sample the dut just took
  cont_key_t k1_q = '0, k2_q = '0;
  logic l3_q = 1'b0, l4_q = 1'b0, l5_q = 1'b0;
  color3_t r_q = '0, g_q = '0, b_q = '0;
  logic hs_n_q = 1'b1, vs_n_q = 1'b1, hb_q = 1'b1, vb_q = 1'b1;
  audio_t aud_q = '0, aud_smp = '0;

  // reference model state
  logic rot_l_m = 1'b1, rot_r_m = 1'b1, abort_m = 1'b1, coin_m = 1'b1;
  logic sel_n_m = 1'b1, start_m = 1'b1, a_m = 1'b0, b_m = 1'b0;
  int tick_m = 0;
  thrust_t thr_m = '0;
  diff_t diff_m = '0;
  longint edge_n = 0, last_sel_edge = 0;
  logic sel_seen = 1'b0, show_m = 1'b0;
  rgb24_t rgb_m = '0;
  logic de_m = 1'b0, hs_m = 1'b0, vs_m = 1'b0, hs_last = 1'b1, vs_last = 1'b1;
  int acc_m = 0;
  logic sclk_m = 1'b0;
  // falling sclk slots within the current channel
  int slot_m = 0;
  logic lrck_m = 1'b1;
  // i2s frame capture
  logic sclk_prev = 1'b0, lrck_prev = 1'b1, lrck_seen = 1'b0;
  int bit_idx = 0;
  i2s_word_t word_m = '0;
  logic seen_max = 1'b0, seen_zero = 1'b0;

  always #(CLK_PERIOD / 2) clk_50 = ~clk_50;

  lander_io_top #(
    .THRUST_TICK (THRUST_TICK_TB),
    .DIFF_SHOW   (DIFF_SHOW_TB),
    .SCLK_STEP   (SCLK_STEP_TB),
    .SCLK_MOD    (SCLK_MOD_TB)
  ) DUT (.*);

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // 3-bit channel to a full byte, upper bits repeated
  function automatic logic [7:0] widen(input color3_t c);
    return {c, c, c[2:1]};
  endfunction

  // slot 0 is the one-bit delay, then 16 data bits, then zeros
  function automatic logic dac_bit(input i2s_word_t w, input int idx);
    if (idx >= 1 && idx <= 16)
      return w[16-idx];
    return 1'b0;
  endfunction

  task automatic apply_inputs();
    i_cont1_key <= k1_q;
    i_cont2_key <= k2_q;
    i_lamp3     <= l3_q;
    i_lamp4     <= l4_q;
    i_lamp5     <= l5_q;
    i_r         <= r_q;
    i_g         <= g_q;
    i_b         <= b_q;
    i_hsync_n   <= hs_n_q;
    i_vsync_n   <= vs_n_q;
    i_hblank    <= hb_q;
    i_vblank    <= vb_q;
    i_audio     <= aud_q;
  endtask

  task automatic drive_inputs(input longint cyc, input logic [1:0] ab);
    logic sel_press;
    logic to_cont1;
    k1_q = cont_key_t'($random(seed));
    k2_q = cont_key_t'($random(seed));
    // select and the throttle keys come from their own sources
    k1_q[`LL_KEY_SELECT] = 1'b0;
    k2_q[`LL_KEY_SELECT] = 1'b0;
    k1_q[`LL_KEY_A] = 1'b0;
    k2_q[`LL_KEY_A] = 1'b0;
    k1_q[`LL_KEY_B] = 1'b0;
    k2_q[`LL_KEY_B] = 1'b0;
    // rare select taps so the overlay flag gets to drop
    sel_press = (($random(seed) & 127) == 0);
    to_cont1  = $random(seed) & 1;
    if (to_cont1) begin
      k1_q[`LL_KEY_SELECT] = sel_press;
      k1_q[`LL_KEY_A] = ab[0];
      k1_q[`LL_KEY_B] = ab[1];
    end else begin
      k2_q[`LL_KEY_SELECT] = sel_press;
      k2_q[`LL_KEY_A] = ab[0];
      k2_q[`LL_KEY_B] = ab[1];
    end
    {l5_q, l4_q, l3_q} = 3'($random(seed));
    {r_q, g_q, b_q} = 9'($random(seed));
    hb_q = (($random(seed) & 7) == 0);
    vb_q = (($random(seed) & 15) == 0);
    {hs_n_q, vs_n_q} = 2'($random(seed));
    // sample held for a whole frame
    if (cyc % FRAME_CYC == 0)
      aud_q = audio_t'($random(seed));
    apply_inputs();
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference models, one call per rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic model_step();
    cont_key_t keys;
    thrust_t thr_next;
    keys = k1_q | k2_q;
    edge_n++;
    // overlay timer sees select as registered before this edge
    if (!sel_n_m) begin
      sel_seen = 1'b1;
      last_sel_edge = edge_n;
    end
    show_m = sel_seen && (edge_n - last_sel_edge < DIFF_SHOW_TB);
    diff_m = l5_q ? 2'd3 : l4_q ? 2'd2 : l3_q ? 2'd1 : 2'd0;
    // throttle step every tick+1 edges, increment wins
    thr_next = thr_m;
    if (tick_m == THRUST_TICK_TB) begin
      if (b_m && thr_m > 0)
        thr_next = thr_m - 1'b1;
      if (a_m && thr_m < `LL_THRUST_MAX)
        thr_next = thr_m + 1'b1;
      tick_m = 0;
    end else begin
      tick_m++;
    end
    thr_m = thr_next;
    if (thr_m == `LL_THRUST_MAX)
      seen_max = 1'b1;
    if (seen_max && thr_m == 0)
      seen_zero = 1'b1;
    a_m     = keys[`LL_KEY_A];
    b_m     = keys[`LL_KEY_B];
    rot_l_m = ~keys[`LL_KEY_UP];
    rot_r_m = ~keys[`LL_KEY_DOWN];
    abort_m = ~keys[`LL_KEY_L1];
    coin_m  = ~keys[`LL_KEY_R1];
    sel_n_m = ~keys[`LL_KEY_SELECT];
    start_m = ~keys[`LL_KEY_START];
    // video
    de_m    = ~(hb_q | vb_q);
    rgb_m   = de_m ? {widen(r_q), widen(g_q), widen(b_q)} : '0;
    hs_m    = hs_last & ~hs_n_q;
    vs_m    = vs_last & ~vs_n_q;
    hs_last = hs_n_q;
    vs_last = vs_n_q;
    // bit clock accumulator
    acc_m += SCLK_STEP_TB;
    if (acc_m >= SCLK_MOD_TB) begin
      acc_m -= SCLK_MOD_TB;
      // lrck flips on the 32nd falling sclk of a channel
      if (sclk_m) begin
        slot_m++;
        if (slot_m == 32) begin
          slot_m = 0;
          lrck_m = ~lrck_m;
        end
      end
      sclk_m = ~sclk_m;
    end
    aud_smp = aud_q;
  endtask

  task automatic check_outputs();
    check_value("o_rot_left_n", o_rot_left_n, rot_l_m);
    check_value("o_rot_right_n", o_rot_right_n, rot_r_m);
    check_value("o_abort_n", o_abort_n, abort_m);
    check_value("o_coin_n", o_coin_n, coin_m);
    check_value("o_game_sel_n", o_game_sel_n, sel_n_m);
    check_value("o_start_n", o_start_n, start_m);
    check_value("o_thrust", o_thrust, thr_m);
    check_value("o_difficulty", o_difficulty, diff_m);
    check_value("o_diff_show", o_diff_show, show_m);
    check_value("o_rgb", o_rgb, rgb_m);
    check_value("o_de", o_de, de_m);
    check_value("o_hs", o_hs, hs_m);
    check_value("o_vs", o_vs, vs_m);
    check_value("o_sclk", o_sclk, sclk_m);
    check_value("o_lrck", o_lrck, lrck_m);
    // new channel, reload from the sample taken at this edge
    if (o_lrck !== lrck_prev) begin
      if (lrck_seen)
        check_value("sclk rises per channel", bit_idx, 32);
      lrck_seen = 1'b1;
      bit_idx   = 0;
      word_m    = {aud_smp, aud_smp};
    end else if (o_sclk && !sclk_prev && lrck_seen) begin
      check_value("o_dac", o_dac, dac_bit(word_m, bit_idx));
      bit_idx++;
    end
    sclk_prev = o_sclk;
    lrck_prev = o_lrck;
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    int p;
    int c;
    longint cyc;
    i_rst_n <= 1'b0;
    apply_inputs();
    // full ramp up, full ramp down, then random a/b phases
    phase_ab[0]  = 2'b01;
    phase_len[0] = RAMP_LEN;
    phase_ab[1]  = 2'b10;
    phase_len[1] = RAMP_LEN;
    total_cycles = 2 * RAMP_LEN;
    for (p = 2; p < NPHASE; p++) begin
      phase_ab[p]  = 2'($random(seed));
      phase_len[p] = 2 * (THRUST_TICK_TB + 1) + ($random(seed) & 255);
      total_cycles += phase_len[p];
    end
    repeat (RESET_CYC) @(posedge clk_50);
    i_rst_n <= 1'b1;
    cyc = 0;
    for (p = 0; p < NPHASE; p++) begin
      for (c = 0; c < phase_len[p]; c++) begin
        @(posedge clk_50);
        model_step();
        drive_inputs(cyc, phase_ab[p]);
        cyc++;
        @(negedge clk_50);
        check_outputs();
      end
    end
    if (!seen_max || !seen_zero) begin
      $display("throttle never went from its ceiling back down to zero");
      $display("Test failed");
      $fatal(1, "throttle range not covered");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

  // all phases plus reset, with a tenth on top
  initial begin
    wait (total_cycles != 0);
    #((RESET_CYC + total_cycles) * CLK_PERIOD * 11 / 10);
    $display("watchdog expired, the stimulus did not finish in time");
    $display("Test failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

//--- hw/lander_controls.sv
// input side of the lander glue
// merges two controllers into the game's active-low buttons and
// ramps the throttle up and down from the a and b face buttons

`include "lander_settings.svh"

module lander_controls import lander_pkg::*; #(
  parameter int THRUST_TICK = `LL_THRUST_TICK
) (
  input  logic      clk_50,
  input  logic      i_rst_n,
  input  cont_key_t i_cont1_key,
  input  cont_key_t i_cont2_key,
  output logic      o_rot_left_n,
  output logic      o_rot_right_n,
  output logic      o_abort_n,
  output logic      o_coin_n,
  output logic      o_game_sel_n,
  output logic      o_start_n,
  output thrust_t   o_thrust
);

  // tick counter runs 0..THRUST_TICK inclusive
  localparam int CNT_W = $clog2(THRUST_TICK + 1);
  localparam logic [CNT_W-1:0] TICK_LAST = CNT_W'(THRUST_TICK);

  cont_key_t        any_key;
  logic             a_held;
  logic             b_held;
  logic [CNT_W-1:0] tick_cnt;
  logic             step;

  // either player can press any button
  assign any_key = i_cont1_key | i_cont2_key;

  //////////////////////////////////////////////////////////////////////
  // game buttons, one register stage, inverted to active low
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rot_left_n  <= 1'b1;
      o_rot_right_n <= 1'b1;
      o_abort_n     <= 1'b1;
      o_coin_n      <= 1'b1;
      o_game_sel_n  <= 1'b1;
      o_start_n     <= 1'b1;
      a_held        <= 1'b0;
      b_held        <= 1'b0;
    end else begin
      // dpad up/down rotate the lander
      o_rot_left_n  <= ~any_key[`LL_KEY_UP];
      o_rot_right_n <= ~any_key[`LL_KEY_DOWN];
      o_abort_n     <= ~any_key[`LL_KEY_L1];
      // r1 doubles as the coin slot
      o_coin_n      <= ~any_key[`LL_KEY_R1];
      o_game_sel_n  <= ~any_key[`LL_KEY_SELECT];
      o_start_n     <= ~any_key[`LL_KEY_START];
      // throttle buttons stay active high
      a_held        <= any_key[`LL_KEY_A];
      b_held        <= any_key[`LL_KEY_B];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // throttle ramp
  //////////////////////////////////////////////////////////////////////

  assign step = (tick_cnt == TICK_LAST);

  // free running, wraps after the last count
  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      tick_cnt <= '0;
    end else if (step) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // saturating up/down, a beats b when both are held
  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_thrust <= '0;
    end else if (step) begin
      if (b_held && (o_thrust != '0))
        o_thrust <= o_thrust - 1'b1;
      // later assignment wins
      if (a_held && (o_thrust < thrust_t'(`LL_THRUST_MAX)))
        o_thrust <= o_thrust + 1'b1;
    end
  end

endmodule

//--- hw/lander_difficulty.sv
// difficulty code from the game's lamp outputs, plus the overlay flag
// that stays up for a while after select is pressed

`include "lander_settings.svh"

module lander_difficulty import lander_pkg::*; #(
  parameter int DIFF_SHOW = `LL_DIFF_SHOW
) (
  input  logic  clk_50,
  input  logic  i_rst_n,
  input  logic  i_game_sel_n,
  input  logic  i_lamp3,
  input  logic  i_lamp4,
  input  logic  i_lamp5,
  output diff_t o_difficulty,
  output logic  o_diff_show
);

  localparam int CNT_W = $clog2(DIFF_SHOW + 1);

  logic [CNT_W-1:0] show_cnt;

  // highest lit lamp decides
  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_difficulty <= '0;
    end else if (i_lamp5) begin
      o_difficulty <= 2'd3;
    end else if (i_lamp4) begin
      o_difficulty <= 2'd2;
    end else if (i_lamp3) begin
      o_difficulty <= 2'd1;
    end else begin
      o_difficulty <= 2'd0;
    end
  end

  // reload while select is held, then run down to zero
  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      show_cnt <= '0;
    end else if (!i_game_sel_n) begin
      show_cnt <= CNT_W'(DIFF_SHOW);
    end else if (show_cnt != '0) begin
      show_cnt <= show_cnt - 1'b1;
    end
  end

  assign o_diff_show = (show_cnt != '0);

endmodule

//--- hw/lander_i2s_tx.sv
// i2s transmitter for the 8-bit game sample
// bit clock edges come from a fractional accumulator on clk_50;
// each channel carries the sample doubled to 16 bits, then 16 zeros

`include "lander_settings.svh"

module lander_i2s_tx import lander_pkg::*; #(
  parameter int SCLK_STEP = `LL_SCLK_STEP,
  parameter int SCLK_MOD  = `LL_SCLK_MOD
) (
  input  logic   clk_50,
  input  logic   i_rst_n,
  input  audio_t i_audio,
  output logic   o_sclk,
  output logic   o_lrck,
  output logic   o_dac
);

  // wide enough for the largest sum, (mod - 1) + step
  localparam int ACC_W = $clog2(SCLK_MOD + SCLK_STEP);

  logic [ACC_W-1:0] acc_q;
  logic [ACC_W-1:0] acc_sum;
  logic             tick;
  logic             fall;
  logic [4:0]       bit_cnt;
  i2s_word_t        shifter;

  //////////////////////////////////////////////////////////////////////
  // bit clock
  //////////////////////////////////////////////////////////////////////

  assign acc_sum = acc_q + ACC_W'(SCLK_STEP);
  assign tick    = (acc_sum >= ACC_W'(SCLK_MOD));

  // the remainder carries over so the average rate is exact
  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      acc_q <= '0;
    end else if (tick) begin
      acc_q <= acc_sum - ACC_W'(SCLK_MOD);
    end else begin
      acc_q <= acc_sum;
    end
  end

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_sclk <= 1'b0;
    end else if (tick) begin
      o_sclk <= ~o_sclk;
    end
  end

  // tick that takes sclk from high to low
  assign fall = tick & o_sclk;

  //////////////////////////////////////////////////////////////////////
  // frame serializer, updates on the falling sclk edge
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_dac   <= 1'b0;
      o_lrck  <= 1'b1;
      bit_cnt <= '0;
      shifter <= '0;
    end else if (fall) begin
      // msb out first
      o_dac   <= shifter[15];
      // 32 slots per channel, wraps on its own
      bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt == 5'd31) begin
        // next channel, fresh copy of the sample
        o_lrck  <= ~o_lrck;
        shifter <= {i_audio, i_audio};
      end else if (bit_cnt < 5'd16) begin
        // zeros fill in behind the data bits
        shifter <= {shifter[14:0], 1'b0};
      end
    end
  end

endmodule

//--- hw/lander_io_top.sv
// top of the lander glue logic, sits between the handheld and the game core
// controls, difficulty, video out and i2s audio on one clk_50 domain

`include "lander_settings.svh"

module lander_io_top import lander_pkg::*; #(
  parameter int THRUST_TICK = `LL_THRUST_TICK,
  parameter int DIFF_SHOW   = `LL_DIFF_SHOW,
  parameter int SCLK_STEP   = `LL_SCLK_STEP,
  parameter int SCLK_MOD    = `LL_SCLK_MOD
) (
  input  logic      clk_50,
  input  logic      i_rst_n,
  // controllers
  input  cont_key_t i_cont1_key,
  input  cont_key_t i_cont2_key,
  // game buttons and throttle
  output logic      o_rot_left_n,
  output logic      o_rot_right_n,
  output logic      o_abort_n,
  output logic      o_start_n,
  output logic      o_coin_n,
  output logic      o_game_sel_n,
  output thrust_t   o_thrust,
  // lamps in, difficulty out
  input  logic      i_lamp3,
  input  logic      i_lamp4,
  input  logic      i_lamp5,
  output diff_t     o_difficulty,
  output logic      o_diff_show,
  // game video in, scaler video out
  input  color3_t   i_r,
  input  color3_t   i_g,
  input  color3_t   i_b,
  input  logic      i_hsync_n,
  input  logic      i_vsync_n,
  input  logic      i_hblank,
  input  logic      i_vblank,
  output rgb24_t    o_rgb,
  output logic      o_de,
  output logic      o_hs,
  output logic      o_vs,
  // audio
  input  audio_t    i_audio,
  output logic      o_sclk,
  output logic      o_lrck,
  output logic      o_dac
);

  // select level shared with the overlay timer
  logic game_sel_n;

  assign o_game_sel_n = game_sel_n;

  lander_controls #(
    .THRUST_TICK (THRUST_TICK)
  ) u_controls (
    .clk_50        (clk_50),
    .i_rst_n       (i_rst_n),
    .i_cont1_key   (i_cont1_key),
    .i_cont2_key   (i_cont2_key),
    .o_rot_left_n  (o_rot_left_n),
    .o_rot_right_n (o_rot_right_n),
    .o_abort_n     (o_abort_n),
    .o_coin_n      (o_coin_n),
    .o_game_sel_n  (game_sel_n),
    .o_start_n     (o_start_n),
    .o_thrust      (o_thrust)
  );

  lander_difficulty #(
    .DIFF_SHOW (DIFF_SHOW)
  ) u_difficulty (
    .clk_50       (clk_50),
    .i_rst_n      (i_rst_n),
    .i_game_sel_n (game_sel_n),
    .i_lamp3      (i_lamp3),
    .i_lamp4      (i_lamp4),
    .i_lamp5      (i_lamp5),
    .o_difficulty (o_difficulty),
    .o_diff_show  (o_diff_show)
  );

  lander_video_out u_video_out (
    .clk_50    (clk_50),
    .i_rst_n   (i_rst_n),
    .i_r       (i_r),
    .i_g       (i_g),
    .i_b       (i_b),
    .i_hsync_n (i_hsync_n),
    .i_vsync_n (i_vsync_n),
    .i_hblank  (i_hblank),
    .i_vblank  (i_vblank),
    .o_rgb     (o_rgb),
    .o_de      (o_de),
    .o_hs      (o_hs),
    .o_vs      (o_vs)
  );

  lander_i2s_tx #(
    .SCLK_STEP (SCLK_STEP),
    .SCLK_MOD  (SCLK_MOD)
  ) u_i2s_tx (
    .clk_50  (clk_50),
    .i_rst_n (i_rst_n),
    .i_audio (i_audio),
    .o_sclk  (o_sclk),
    .o_lrck  (o_lrck),
    .o_dac   (o_dac)
  );

endmodule

//--- hw/lander_pkg.sv
// shared vector types for the lander glue logic
// imported by the rtl modules and by the testbench

package lander_pkg;

  //////////////////////////////////////////////////////////////////////
  // controller side
  //////////////////////////////////////////////////////////////////////

  // one controller's key bitmap, active high
  typedef logic [15:0] cont_key_t;

  // throttle level fed to the game
  typedef logic [7:0]  thrust_t;

  // difficulty code taken from the lamps
  typedef logic [1:0]  diff_t;

  //////////////////////////////////////////////////////////////////////
  // video side
  //////////////////////////////////////////////////////////////////////

  // one colour channel as the game drives it
  typedef logic [2:0]  color3_t;

  // scaler pixel, r in the top byte
  typedef logic [23:0] rgb24_t;

  //////////////////////////////////////////////////////////////////////
  // audio side
  //////////////////////////////////////////////////////////////////////

  // unsigned game sample
  typedef logic [7:0]  audio_t;

  // one i2s channel word, msb first
  typedef logic [15:0] i2s_word_t;

endpackage

//--- hw/lander_settings.svh
// timing constants and controller key positions for the lander glue logic
// include in any module that needs a default tick length or a key bit

`ifndef LANDER_SETTINGS_SVH
`define LANDER_SETTINGS_SVH

// throttle steps every tick+1 cycles, about one second to full scale
`define LL_THRUST_TICK 196850
// throttle ceiling
`define LL_THRUST_MAX  254

// difficulty overlay hold, ten seconds at 50 MHz
`define LL_DIFF_SHOW   500000000

// 3.072 MHz sclk half periods from clk_50: 50e6 * 6144 / 50000 = 6.144e6 edges/s
`define LL_SCLK_STEP   6144
`define LL_SCLK_MOD    50000

// controller key bitmap positions
`define LL_KEY_UP      0
`define LL_KEY_DOWN    1
`define LL_KEY_A       4
`define LL_KEY_B       5
`define LL_KEY_L1      8
`define LL_KEY_R1      9
`define LL_KEY_SELECT  14
`define LL_KEY_START   15

`endif

//--- hw/lander_video_out.sv
// video output stage towards the scaler
// widens the 3-bit channels to 24-bit rgb, blanks outside the active
// area and turns the active-low syncs into one-cycle start pulses

module lander_video_out import lander_pkg::*; (
  input  logic    clk_50,
  input  logic    i_rst_n,
  input  color3_t i_r,
  input  color3_t i_g,
  input  color3_t i_b,
  input  logic    i_hsync_n,
  input  logic    i_vsync_n,
  input  logic    i_hblank,
  input  logic    i_vblank,
  output rgb24_t  o_rgb,
  output logic    o_de,
  output logic    o_hs,
  output logic    o_vs
);

  logic   active;
  rgb24_t pix_wide;
  logic   hsync_n_q;
  logic   vsync_n_q;

  assign active = ~(i_hblank | i_vblank);

  // bit replication keeps full white at 8'hff
  assign pix_wide = {{i_r, i_r, i_r[2:1]},
                     {i_g, i_g, i_g[2:1]},
                     {i_b, i_b, i_b[2:1]}};

  //////////////////////////////////////////////////////////////////////
  // pixel and data enable
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rgb <= '0;
      o_de  <= 1'b0;
    end else begin
      o_de  <= active;
      // scaler wants black outside the active area
      o_rgb <= active ? pix_wide : '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sync start pulses
  //////////////////////////////////////////////////////////////////////

  // falling edge of each active-low sync
  always_ff @(posedge clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      hsync_n_q <= 1'b1;
      vsync_n_q <= 1'b1;
      o_hs      <= 1'b0;
      o_vs      <= 1'b0;
    end else begin
      hsync_n_q <= i_hsync_n;
      vsync_n_q <= i_vsync_n;
      o_hs      <= hsync_n_q & ~i_hsync_n;
      o_vs      <= vsync_n_q & ~i_vsync_n;
    end
  end

endmodule

//--- list.f
+incdir+hw
hw/lander_pkg.sv
hw/lander_controls.sv
hw/lander_difficulty.sv
hw/lander_video_out.sv
hw/lander_i2s_tx.sv
hw/lander_io_top.sv
dv/lander_checker.sv
dv/lander_tb.sv
